// File: Bender.yml
package:
  name: cipherAccel

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cipherPkg.sv
      - ahbSlave/cipherRegBank.sv
      - ahbSlave/ahbLiteSlaveController.sv
      - cipherCore/feistelEngine.sv
      - verilog/cipherTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/cipherChecker.sv
      - dv/tb_cipherTop.sv

// File: ahbSlave/ahbLiteSlaveController.sv
// AHB-Lite slave control for the cipher accelerator
// Transfer FSM with wait states and two-cycle ERROR,
// plus the single/EDE pass sequencer that drives the engine
`timescale 1ns/1ns
`default_nettype none
`include "cipher_cfg.svh"

module ahbLiteSlaveController (
  input  wire logic                    HCLK,
  input  wire logic                    reset,
  input  wire logic                    HSEL,
  input  wire logic [31:0]             HADDR,
  input  wire cipherPkg::ahbTrans_e    HTRANS,
  input  wire logic                    HWRITE,
  input  wire logic [2:0]              HSIZE,
  input  wire logic                    HREADY,
  input  wire logic                    startPulse,
  input  wire cipherPkg::ctrlWord_u    ctrl,
  input  wire logic [`BUS_WIDTH-1:0]   keys [3],
  input  wire logic [`BUS_WIDTH-1:0]   dataReg,
  input  wire logic                    reqReady,
  input  wire logic                    resValid,
  input  wire cipherPkg::passRes_t     res,
  output logic                         HREADYOUT,
  output logic                         HRESP,
  output logic                         wrEn,
  output cipherPkg::regIndex_e         wrIdx,
  output cipherPkg::regIndex_e         rdIdx,
  output logic                         resWr,
  output cipherPkg::cipherStatus_t     status,
  output logic                         reqValid,
  output cipherPkg::passReq_t          req
);

  typedef enum logic [2:0] {IDLE, DATA, STALL, ERR1, ERR2} busState_e;

  busState_e            state, nextState;
  cipherPkg::regIndex_e capIdx;
  logic                 capWrite;
  logic                 accept, badAccess, dataPhase, engaged, needStall, writable;
  logic                 busy, done, lastPass;
  logic [1:0]           passCnt, keySel;
  logic                 opTriple, opDecrypt;
  logic [`BUS_WIDTH-1:0] opKeys [3];
  logic [`BUS_WIDTH-1:0] curBlock;

  assign accept = HSEL && HREADY &&
                  (HTRANS == cipherPkg::TRANS_NONSEQ || HTRANS == cipherPkg::TRANS_SEQ);
  assign badAccess = (HSIZE != `HSIZE_64) ||
                     (HADDR[`ADDR_IDX_MSB:`ADDR_IDX_LSB] > `REG_STATUS);

  // A start just written counts as busy until the sequencer picks it up
  assign engaged   = busy || startPulse;
  assign dataPhase = (state == DATA) || (state == STALL);
  // Hold CTRL writes so the running mode cannot change, hold RESULT reads until stored
  assign needStall = dataPhase && engaged &&
                     (capWrite ? (capIdx == cipherPkg::IDX_CTRL)
                               : (capIdx == cipherPkg::IDX_RESULT));
  assign writable  = capIdx inside {cipherPkg::IDX_CTRL, cipherPkg::IDX_DATA,
                                    cipherPkg::IDX_KEY1, cipherPkg::IDX_KEY2,
                                    cipherPkg::IDX_KEY3};

  assign wrEn      = dataPhase && !needStall && capWrite && writable;
  assign wrIdx     = capIdx;
  assign rdIdx     = capIdx;
  assign HREADYOUT = !((state == ERR1) || needStall);
  assign HRESP     = (state == ERR1) || (state == ERR2);

  always_comb
  begin
    if (state == ERR1)
      nextState = ERR2;
    else if (needStall)
      nextState = STALL;
    else if (accept)
      nextState = badAccess ? ERR1 : DATA;
    else
      nextState = IDLE;
  end

  always_ff @(posedge HCLK)
  begin
    if (reset)
    begin
      state    <= IDLE;
      capIdx   <= cipherPkg::IDX_CTRL;
      capWrite <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (accept)
      begin
        capIdx   <= cipherPkg::regIndex_e'(HADDR[`ADDR_IDX_MSB:`ADDR_IDX_LSB]);
        capWrite <= HWRITE;
      end
    end
  end

  // Pass sequencing
  assign lastPass = opTriple ? (passCnt == 2'd2) : (passCnt == 2'd0);
  assign resWr    = resValid && lastPass;
  // Triple decrypt walks the keys backwards
  assign keySel   = !opTriple ? 2'd0 : (opDecrypt ? 2'd2 - passCnt : passCnt);

  assign req.block   = curBlock;
  assign req.key     = opKeys[keySel];
  assign req.decrypt = opDecrypt ^ (opTriple && passCnt == 2'd1);

  always_comb
  begin
    status      = '0;
    status.busy = busy;
    status.done = done;
  end

  always_ff @(posedge HCLK)
  begin
    if (reset)
    begin
      busy      <= 1'b0;
      done      <= 1'b0;
      passCnt   <= 2'd0;
      reqValid  <= 1'b0;
      opTriple  <= 1'b0;
      opDecrypt <= 1'b0;
    end
    else if (startPulse)
    begin
      busy      <= 1'b1;
      done      <= 1'b0;
      passCnt   <= 2'd0;
      reqValid  <= 1'b1;
      opTriple  <= ctrl.fields.triple;
      opDecrypt <= ctrl.fields.decrypt;
    end
    else
    begin
      if (reqValid && reqReady)
        reqValid <= 1'b0;
      if (resValid)
      begin
        if (lastPass)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
        else
        begin
          passCnt  <= passCnt + 2'd1;
          reqValid <= 1'b1;
        end
      end
    end
  end

  // Operands latched at start, block replaced by each pass result
  always_ff @(posedge HCLK)
  begin
    if (startPulse)
    begin
      opKeys   <= keys;
      curBlock <= dataReg;
    end
    else if (resValid)
      curBlock <= res.block;
  end

  hrespTwoCycles: assert property (@(posedge HCLK) disable iff (reset)
    $rose(HRESP) |=> HRESP);

  reqHeldUntilReady: assert property (@(posedge HCLK) disable iff (reset)
    reqValid && !reqReady |=> reqValid && $stable(req));

endmodule

`default_nettype wire

// File: ahbSlave/cipherRegBank.sv
// Register bank of the cipher accelerator
// Data, key, control and result storage, CTRL decode
// into the start pulse, and the HRDATA read mux
`timescale 1ns/1ns
`default_nettype none
`include "cipher_cfg.svh"

module cipherRegBank (
  input  wire logic                    HCLK,
  input  wire logic                    reset,
  input  wire logic                    wrEn,
  input  wire cipherPkg::regIndex_e    wrIdx,
  input  wire cipherPkg::regIndex_e    rdIdx,
  input  wire logic [`BUS_WIDTH-1:0]   HWDATA,
  input  wire logic                    resWr,
  input  wire cipherPkg::passRes_t     res,
  input  wire cipherPkg::cipherStatus_t status,
  output cipherPkg::ctrlWord_u         ctrl,
  output logic [`BUS_WIDTH-1:0]        dataReg,
  output logic [`BUS_WIDTH-1:0]        keys [3],
  output logic                         startPulse,
  output logic [`BUS_WIDTH-1:0]        HRDATA
);

  cipherPkg::ctrlWord_u  wrWord;
  logic [`BUS_WIDTH-1:0] result;

  assign wrWord.raw = HWDATA;

  always_ff @(posedge HCLK)
  begin
    if (reset)
    begin
      ctrl       <= '0;
      dataReg    <= '0;
      keys       <= '{default: '0};
      result     <= '0;
      startPulse <= 1'b0;
    end
    else
    begin
      // Pulse lines up with the new CTRL value
      startPulse <= wrEn && (wrIdx == cipherPkg::IDX_CTRL) && wrWord.fields.start;
      if (wrEn)
      begin
        case (wrIdx)
          cipherPkg::IDX_CTRL: ctrl    <= wrWord;
          cipherPkg::IDX_DATA: dataReg <= HWDATA;
          cipherPkg::IDX_KEY1: keys[0] <= HWDATA;
          cipherPkg::IDX_KEY2: keys[1] <= HWDATA;
          cipherPkg::IDX_KEY3: keys[2] <= HWDATA;
          default: ;
        endcase
      end
      if (resWr)
        result <= res.block;
    end
  end

  always_comb
  begin
    case (rdIdx)
      cipherPkg::IDX_CTRL:   HRDATA = ctrl.raw;
      cipherPkg::IDX_DATA:   HRDATA = dataReg;
      cipherPkg::IDX_KEY1:   HRDATA = keys[0];
      cipherPkg::IDX_KEY2:   HRDATA = keys[1];
      cipherPkg::IDX_KEY3:   HRDATA = keys[2];
      cipherPkg::IDX_RESULT: HRDATA = result;
      cipherPkg::IDX_STATUS: HRDATA = status;
      default:               HRDATA = '0;
    endcase
  end

  // Relies on the controller stalling CTRL writes while a start is pending
  startPulseSingle: assert property (@(posedge HCLK) disable iff (reset)
    startPulse |=> !startPulse);

endmodule

`default_nettype wire

// File: cipherAccel.f
+incdir+common
common/cipherPkg.sv
ahbSlave/cipherRegBank.sv
ahbSlave/ahbLiteSlaveController.sv
cipherCore/feistelEngine.sv
verilog/cipherTop.sv
dv/cipherChecker.sv
dv/tb_cipherTop.sv

// File: cipherCore/feistelEngine.sv
// Iterative 64-bit Feistel engine, one round per clock
// Round key schedule, round function and direction control
// Load cycle then CIPHER_ROUNDS rounds per pass
`timescale 1ns/1ns
`default_nettype none
`include "cipher_cfg.svh"

module feistelEngine (
  input  wire logic                HCLK,
  input  wire logic                reset,
  input  wire logic                reqValid,
  input  wire cipherPkg::passReq_t req,
  output logic                     reqReady,
  output logic                     resValid,
  output cipherPkg::passRes_t      res
);

  localparam int RndBits   = $clog2(`CIPHER_ROUNDS);
  localparam int HalfWidth = `BUS_WIDTH / 2;

  logic [HalfWidth-1:0]  left, right;
  logic [`BUS_WIDTH-1:0] key;
  logic                  decrypt;
  logic                  running;
  logic                  accept;
  logic [RndBits-1:0]    rnd, keyIdx;
  logic [HalfWidth-1:0]  roundKey, fOut, nextRight;

  function automatic logic [HalfWidth-1:0] rotl(input logic [HalfWidth-1:0] x,
                                                input int amt);
    int a;
    a = amt % HalfWidth;
    return (x << a) | (x >> (HalfWidth - a));
  endfunction

  // Only one pass in flight
  assign reqReady = !running;
  assign accept   = reqValid && reqReady;

  // Decrypt walks the schedule from the last round key down
  assign keyIdx   = decrypt ? RndBits'(`CIPHER_ROUNDS - 1) - rnd : rnd;
  assign roundKey = rotl(key[`BUS_WIDTH-1:HalfWidth], 3 * int'(keyIdx)) +
                    key[HalfWidth-1:0] + HalfWidth'(keyIdx);

  // F(R, k)
  assign fOut      = (rotl(right, 5) + roundKey) ^ (right >> 3);
  assign nextRight = left ^ fOut;

  // Halves swapped back on the way out for decrypt
  assign res.block = decrypt ? {right, left} : {left, right};

  always_ff @(posedge HCLK)
  begin
    if (reset)
    begin
      running  <= 1'b0;
      resValid <= 1'b0;
      rnd      <= '0;
    end
    else
    begin
      resValid <= 1'b0;
      if (accept)
      begin
        running <= 1'b1;
        rnd     <= '0;
      end
      else if (running)
      begin
        rnd <= rnd + 1'b1;
        if (rnd == RndBits'(`CIPHER_ROUNDS - 1))
        begin
          running  <= 1'b0;
          resValid <= 1'b1;
        end
      end
    end
  end

  // Round datapath
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      key     <= req.key;
      decrypt <= req.decrypt;
      if (req.decrypt)
        {left, right} <= {req.block[HalfWidth-1:0], req.block[`BUS_WIDTH-1:HalfWidth]};
      else
        {left, right} <= req.block;
    end
    else if (running)
    begin
      left  <= right;
      right <= nextRight;
    end
  end

  passLatency: assert property (@(posedge HCLK) disable iff (reset)
    accept |=> !resValid [*`CIPHER_ROUNDS] ##1 resValid);

endmodule

`default_nettype wire

// File: common/cipherPkg.sv
// Shared types of the cipher accelerator
// Register index and HTRANS enums, control word union,
// engine request and result structs, status word
`default_nettype none
`include "cipher_cfg.svh"

package cipherPkg;

  typedef enum logic [2:0] {
    IDX_CTRL   = `REG_CTRL,
    IDX_DATA   = `REG_DATA,
    IDX_KEY1   = `REG_KEY1,
    IDX_KEY2   = `REG_KEY2,
    IDX_KEY3   = `REG_KEY3,
    IDX_RESULT = `REG_RESULT,
    IDX_STATUS = `REG_STATUS,
    // Unmapped slot, always answered with ERROR
    IDX_NONE   = 3'd7
  } regIndex_e;

  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,
    TRANS_SEQ    = 2'b11
  } ahbTrans_e;

  // Decoded view of the control register
  typedef struct packed {
    logic [`BUS_WIDTH-4:0] reserved;
    logic                  decrypt;
    logic                  triple;
    logic                  start;
  } ctrlFields_t;

  typedef union packed {
    logic [`BUS_WIDTH-1:0] raw;
    ctrlFields_t           fields;
  } ctrlWord_u;

  // One pass through the engine
  typedef struct packed {
    logic [`BUS_WIDTH-1:0] block;
    logic [`BUS_WIDTH-1:0] key;
    logic                  decrypt;
  } passReq_t;

  typedef struct packed {
    logic [`BUS_WIDTH-1:0] block;
  } passRes_t;

  typedef struct packed {
    logic [`BUS_WIDTH-3:0] reserved;
    logic                  done;
    logic                  busy;
  } cipherStatus_t;

endpackage

`default_nettype wire

// File: common/cipher_cfg.svh
// Build-time constants for the cipher accelerator
// Round count, register map indices and bus widths
`ifndef CIPHER_CFG_SVH
`define CIPHER_CFG_SVH

// Feistel rounds per pass
`define CIPHER_ROUNDS 8

// Register word indices, taken from HADDR[5:3]
`define REG_CTRL   3'd0
`define REG_DATA   3'd1
`define REG_KEY1   3'd2
`define REG_KEY2   3'd3
`define REG_KEY3   3'd4
`define REG_RESULT 3'd5
`define REG_STATUS 3'd6

`define ADDR_IDX_MSB 5
`define ADDR_IDX_LSB 3

// Data bus and block width, and the only legal HSIZE
`define BUS_WIDTH 64
`define HSIZE_64  3'b011

`endif

// File: dv/cipherChecker.sv
// Bus response checker for the cipher accelerator testbench
// Reference Feistel and EDE model, queued transfer expectations,
// per-test and closing check counts
`timescale 1ns/1ns
`default_nettype none
`include "cipher_cfg.svh"

module cipherChecker (
  input wire logic                  HCLK,
  input wire logic                  reset,
  input wire logic                  HSEL,
  input wire logic [1:0]            HTRANS,
  input wire logic                  HREADY,
  input wire logic [`BUS_WIDTH-1:0] HRDATA,
  input wire logic                  HREADYOUT,
  input wire logic                  HRESP
);

  typedef struct packed {
    logic                  isErr;
    logic                  checkData;
    logic                  mustWait;
    logic [`BUS_WIDTH-1:0] data;
  } busExp_t;

  busExp_t expQ[$];
  int      checkCount = 0;
  int      errorCount = 0;
  int      testChecks = 0;
  int      testErrors = 0;
  logic    inData = 1'b0;
  logic    errSeen = 1'b0;
  int      waitCycles = 0;

  function automatic logic [31:0] rotl32(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
  endfunction

  // Round key i from the upper and lower key halves
  function automatic logic [31:0] roundKey(input logic [63:0] key, input int i);
    return rotl32(key[63:32], 3 * i) + key[31:0] + i;
  endfunction

  function automatic logic [31:0] roundF(input logic [31:0] r, input logic [31:0] k);
    return (rotl32(r, 5) + k) ^ (r >> 3);
  endfunction

  function automatic logic [63:0] onePass(input logic [63:0] blk, input logic [63:0] key,
                                          input logic dec);
    logic [31:0] l, r, t;
    int          s;
    int          i;
    // Decrypt swaps halves at load and output, keys run backwards
    if (dec)
      {l, r} = {blk[31:0], blk[63:32]};
    else
      {l, r} = blk;
    for (s = 0; s < `CIPHER_ROUNDS; s++)
    begin
      i = dec ? `CIPHER_ROUNDS - 1 - s : s;
      t = l ^ roundF(r, roundKey(key, i));
      l = r;
      r = t;
    end
    return dec ? {r, l} : {l, r};
  endfunction

  // EDE order, reversed with flipped directions for decrypt
  function automatic logic [63:0] cipherOp(input logic [63:0] blk, input logic [63:0] k1,
                                           input logic [63:0] k2, input logic [63:0] k3,
                                           input logic triple, input logic dec);
    if (!triple)
      return onePass(blk, k1, dec);
    if (!dec)
      return onePass(onePass(onePass(blk, k1, 1'b0), k2, 1'b1), k3, 1'b0);
    return onePass(onePass(onePass(blk, k3, 1'b1), k2, 1'b0), k1, 1'b1);
  endfunction

  task automatic expectTransfer(input logic isErr, input logic checkData,
                                input logic mustWait, input logic [63:0] data);
    expQ.push_back({isErr, checkData, mustWait, data});
  endtask

  // RESULT read whose data comes from the model
  task automatic expectCipher(input logic [63:0] blk, input logic [63:0] k1,
                              input logic [63:0] k2, input logic [63:0] k3,
                              input logic triple, input logic dec, input logic mustWait);
    expectTransfer(1'b0, 1'b1, mustWait, cipherOp(blk, k1, k2, k3, triple, dec));
  endtask

  task automatic recordCheck(input logic ok, input string msg);
    checkCount++;
    testChecks++;
    if (!ok)
    begin
      errorCount++;
      testErrors++;
      $display("FAIL %0t: %s", $time, msg);
    end
  endtask

  task automatic checkTransfer();
    busExp_t e;
    if (expQ.size() == 0)
    begin
      errorCount++;
      testErrors++;
      $display("Error at %0t: a bus transfer completed that the test never issued", $time);
    end
    else
    begin
      e = expQ.pop_front();
      if (e.isErr)
        recordCheck(HRESP === 1'b1 && errSeen && waitCycles == 1,
                    "expected a two-cycle ERROR response");
      else
      begin
        recordCheck(HRESP === 1'b0 && !errSeen, "expected an OKAY response");
        recordCheck((waitCycles > 0) == e.mustWait,
                    $sformatf("unexpected number of wait states %0d", waitCycles));
        if (e.checkData)
          recordCheck(HRDATA === e.data,
                      $sformatf("read data %h, expected %h", HRDATA, e.data));
      end
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge HCLK)
  begin
    if (reset)
      inData = 1'b0;
    else
    begin
      if (inData)
      begin
        if (HREADYOUT !== 1'b1)
        begin
          waitCycles++;
          if (HRESP === 1'b1)
            errSeen = 1'b1;
        end
        else
        begin
          inData = 1'b0;
          checkTransfer();
        end
      end
      if (HSEL && HTRANS[1] && HREADY)
      begin
        inData     = 1'b1;
        waitCycles = 0;
        errSeen    = 1'b0;
      end
    end
  end

  task automatic endTest(input string name);
    $display("%s: %0d checks, %0d errors, %s", name, testChecks, testErrors,
             testErrors == 0 ? "ok" : "failed");
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic finalReport();
    if (expQ.size() != 0)
    begin
      errorCount++;
      $display("Error: %0d issued transfers never completed", expQ.size());
    end
    $display("Total: %0d checks, %0d errors", checkCount, errorCount);
  endtask

endmodule

`default_nettype wire

// File: dv/tb_cipherTop.sv
// Testbench for the cipher accelerator
// Clock, reset, xorshift stimulus, AHB-Lite master tasks,
// test sequence and watchdog
`timescale 1ns/1ns
`default_nettype none
`include "cipher_cfg.svh"

module tb_cipherTop;

  localparam int ClkPeriod   = 10;
  localparam int NumCases    = 20;
  // Readback, single, triple pairs, back-pressure and error tests
  localparam int NumOps      = 1 + NumCases + 2 * NumCases + 3 + 1;
  localparam int CyclesPerOp = 200;

  logic                  HCLK, reset, HSEL, HWRITE, HREADY;
  logic [31:0]           HADDR;
  logic [1:0]            HTRANS;
  logic [2:0]            HSIZE;
  logic [`BUS_WIDTH-1:0] HWDATA, HRDATA;
  logic                  HREADYOUT, HRESP;
  logic [31:0]           rngState;
  logic [`BUS_WIDTH-1:0] lastRead;

  cipherTop cipherTop_i (
    .HCLK     (HCLK),
    .reset    (reset),
    .HSEL     (HSEL),
    .HADDR    (HADDR),
    .HTRANS   (HTRANS),
    .HWRITE   (HWRITE),
    .HSIZE    (HSIZE),
    .HWDATA   (HWDATA),
    .HREADY   (HREADY),
    .HRDATA   (HRDATA),
    .HREADYOUT(HREADYOUT),
    .HRESP    (HRESP)
  );

  cipherChecker cipherChecker_i (
    .HCLK     (HCLK),
    .reset    (reset),
    .HSEL     (HSEL),
    .HTRANS   (HTRANS),
    .HREADY   (HREADY),
    .HRDATA   (HRDATA),
    .HREADYOUT(HREADYOUT),
    .HRESP    (HRESP)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(ClkPeriod / 2) HCLK = ~HCLK;
  end

  // Single slave on the bus, so HREADY follows HREADYOUT
  initial HREADY = 1'b1;
  always @(HREADYOUT) HREADY = HREADYOUT;

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic logic [63:0] rand64();
    return {nextRand(), nextRand()};
  endfunction

  // One non-pipelined transfer, entered and left 1 ns after a rising edge
  task automatic busTransfer(input logic write, input logic [2:0] idx, input logic [2:0] size,
                             input logic [63:0] wdata);
    HSEL   = 1'b1;
    HTRANS = 2'b10;
    HADDR  = {26'd0, idx, 3'b000};
    HWRITE = write;
    HSIZE  = size;
    @(posedge HCLK);
    #1;
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    HWDATA = wdata;
    @(negedge HCLK);
    while (HREADYOUT !== 1'b1)
      @(negedge HCLK);
    lastRead = HRDATA;
    @(posedge HCLK);
    #1;
  endtask

  task automatic writeReg(input logic [2:0] idx, input logic [63:0] data, input logic mustWait);
    cipherChecker_i.expectTransfer(1'b0, 1'b0, mustWait, '0);
    busTransfer(1'b1, idx, `HSIZE_64, data);
  endtask

  task automatic readCheck(input logic [2:0] idx, input logic [63:0] expData,
                           input logic mustWait);
    cipherChecker_i.expectTransfer(1'b0, 1'b1, mustWait, expData);
    busTransfer(1'b0, idx, `HSIZE_64, '0);
  endtask

  task automatic badAccess(input logic write, input logic [2:0] idx, input logic [2:0] size);
    cipherChecker_i.expectTransfer(1'b1, 1'b0, 1'b1, '0);
    busTransfer(write, idx, size, rand64());
  endtask

  task automatic readCipherResult(input logic [63:0] blk, input logic [63:0] k1,
                                  input logic [63:0] k2, input logic [63:0] k3,
                                  input logic triple, input logic dec, input logic mustWait);
    cipherChecker_i.expectCipher(blk, k1, k2, k3, triple, dec, mustWait);
    busTransfer(1'b0, `REG_RESULT, `HSIZE_64, '0);
  endtask

  task automatic loadOperands(input logic [63:0] blk, input logic [63:0] k1,
                              input logic [63:0] k2, input logic [63:0] k3);
    writeReg(`REG_DATA, blk, 1'b0);
    writeReg(`REG_KEY1, k1, 1'b0);
    writeReg(`REG_KEY2, k2, 1'b0);
    writeReg(`REG_KEY3, k3, 1'b0);
  endtask

  // Random reserved bits, then decrypt, triple, start
  task automatic startOp(input logic triple, input logic dec, input logic mustWait);
    logic [63:0] word;
    word      = rand64();
    word[2:0] = {dec, triple, 1'b1};
    writeReg(`REG_CTRL, word, mustWait);
  endtask

  task automatic pollDone();
    lastRead = '0;
    while (!lastRead[1])
    begin
      cipherChecker_i.expectTransfer(1'b0, 1'b0, 1'b0, '0);
      busTransfer(1'b0, `REG_STATUS, `HSIZE_64, '0);
    end
  endtask

  initial
  begin : mainSequence
    logic [63:0] blk, k1, k2, k3, ctrlVal, resBlk, resKey;
    int          n;
    rngState = 32'hc2d3;
    reset    = 1'b1;
    HSEL     = 1'b0;
    HADDR    = '0;
    HTRANS   = 2'b00;
    HWRITE   = 1'b0;
    HSIZE    = `HSIZE_64;
    HWDATA   = '0;
    repeat (10) @(posedge HCLK);
    #1;
    reset = 1'b0;

    for (n = 0; n <= `REG_STATUS; n++)
      readCheck(n[2:0], '0, 1'b0);
    blk = rand64();
    k1  = rand64();
    k2  = rand64();
    k3  = rand64();
    loadOperands(blk, k1, k2, k3);
    readCheck(`REG_DATA, blk, 1'b0);
    readCheck(`REG_KEY1, k1, 1'b0);
    readCheck(`REG_KEY2, k2, 1'b0);
    readCheck(`REG_KEY3, k3, 1'b0);
    cipherChecker_i.endTest("Register readback");

    for (n = 0; n < NumCases; n++)
    begin
      blk = rand64();
      k1  = rand64();
      loadOperands(blk, k1, k2, k3);
      startOp(1'b0, 1'b0, 1'b0);
      pollDone();
      readCipherResult(blk, k1, k2, k3, 1'b0, 1'b0, 1'b0);
    end
    cipherChecker_i.endTest("Single-mode encryption");

    for (n = 0; n < NumCases; n++)
    begin
      blk = rand64();
      k1  = rand64();
      k2  = rand64();
      k3  = rand64();
      loadOperands(blk, k1, k2, k3);
      startOp(1'b1, 1'b0, 1'b0);
      pollDone();
      readCipherResult(blk, k1, k2, k3, 1'b1, 1'b0, 1'b0);
      // Ciphertext goes back in, the plaintext must come out
      writeReg(`REG_DATA, lastRead, 1'b0);
      startOp(1'b1, 1'b1, 1'b0);
      pollDone();
      readCheck(`REG_RESULT, blk, 1'b0);
    end
    cipherChecker_i.endTest("Triple mode both directions");

    blk = rand64();
    k1  = rand64();
    loadOperands(blk, k1, k2, k3);
    startOp(1'b0, 1'b0, 1'b0);
    readCipherResult(blk, k1, k2, k3, 1'b0, 1'b0, 1'b1);
    // Triple op keeps the engine busy while the next operands load
    startOp(1'b1, 1'b0, 1'b0);
    resBlk = rand64();
    resKey = rand64();
    writeReg(`REG_DATA, resBlk, 1'b0);
    writeReg(`REG_KEY1, resKey, 1'b0);
    startOp(1'b0, 1'b0, 1'b1);
    readCipherResult(resBlk, resKey, k2, k3, 1'b0, 1'b0, 1'b1);
    cipherChecker_i.endTest("Back-pressure");

    blk     = rand64();
    k1      = rand64();
    k2      = rand64();
    k3      = rand64();
    ctrlVal = rand64();
    ctrlVal[0] = 1'b0;
    loadOperands(blk, k1, k2, k3);
    writeReg(`REG_CTRL, ctrlVal, 1'b0);
    badAccess(1'b1, `REG_DATA, 3'b010);
    badAccess(1'b0, `REG_KEY1, 3'b010);
    badAccess(1'b1, 3'd7, `HSIZE_64);
    badAccess(1'b0, 3'd7, `HSIZE_64);
    // Read-only registers drop writes with OKAY
    writeReg(`REG_RESULT, rand64(), 1'b0);
    writeReg(`REG_STATUS, rand64(), 1'b0);
    readCheck(`REG_CTRL, ctrlVal, 1'b0);
    readCheck(`REG_DATA, blk, 1'b0);
    readCheck(`REG_KEY1, k1, 1'b0);
    readCheck(`REG_KEY2, k2, 1'b0);
    readCheck(`REG_KEY3, k3, 1'b0);
    readCipherResult(resBlk, resKey, k2, k3, 1'b0, 1'b0, 1'b0);
    readCheck(`REG_STATUS, 64'h2, 1'b0);
    cipherChecker_i.endTest("Error responses");

    cipherChecker_i.finalReport();
    if (cipherChecker_i.errorCount == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    #(CyclesPerOp * NumOps * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", CyclesPerOp * NumOps);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/cipherTop.sv
// Top level of the cipher accelerator
// AHB-Lite pins to controller, register bank and Feistel engine
`timescale 1ns/1ns
`default_nettype none
`include "cipher_cfg.svh"

module cipherTop (
  input  wire logic                  HCLK,
  input  wire logic                  reset,
  input  wire logic                  HSEL,
  input  wire logic [31:0]           HADDR,
  input  wire logic [1:0]            HTRANS,
  input  wire logic                  HWRITE,
  input  wire logic [2:0]            HSIZE,
  input  wire logic [`BUS_WIDTH-1:0] HWDATA,
  input  wire logic                  HREADY,
  output logic [`BUS_WIDTH-1:0]      HRDATA,
  output logic                       HREADYOUT,
  output logic                       HRESP
);

  logic                     wrEn, resWr, startPulse;
  cipherPkg::regIndex_e     wrIdx, rdIdx;
  cipherPkg::ctrlWord_u     ctrl;
  logic [`BUS_WIDTH-1:0]    dataReg;
  logic [`BUS_WIDTH-1:0]    keys [3];
  cipherPkg::cipherStatus_t status;
  // Engine handshake
  logic                     reqValid, reqReady, resValid;
  cipherPkg::passReq_t      req;
  cipherPkg::passRes_t      res;

  ahbLiteSlaveController ahbLiteSlaveController_i (
    .HCLK      (HCLK),
    .reset     (reset),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (cipherPkg::ahbTrans_e'(HTRANS)),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HREADY    (HREADY),
    .startPulse(startPulse),
    .ctrl      (ctrl),
    .keys      (keys),
    .dataReg   (dataReg),
    .reqReady  (reqReady),
    .resValid  (resValid),
    .res       (res),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .wrEn      (wrEn),
    .wrIdx     (wrIdx),
    .rdIdx     (rdIdx),
    .resWr     (resWr),
    .status    (status),
    .reqValid  (reqValid),
    .req       (req)
  );

  cipherRegBank cipherRegBank_i (
    .HCLK      (HCLK),
    .reset     (reset),
    .wrEn      (wrEn),
    .wrIdx     (wrIdx),
    .rdIdx     (rdIdx),
    .HWDATA    (HWDATA),
    .resWr     (resWr),
    .res       (res),
    .status    (status),
    .ctrl      (ctrl),
    .dataReg   (dataReg),
    .keys      (keys),
    .startPulse(startPulse),
    .HRDATA    (HRDATA)
  );

  feistelEngine feistelEngine_i (
    .HCLK    (HCLK),
    .reset   (reset),
    .reqValid(reqValid),
    .req     (req),
    .reqReady(reqReady),
    .resValid(resValid),
    .res     (res)
  );

endmodule

`default_nettype wire
